// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes, RV32I subset handled by this core
    localparam opcode_t OPC_LUI     = 7'b0110111;
    localparam opcode_t OPC_AUIPC   = 7'b0010111;
    localparam opcode_t OPC_JAL     = 7'b1101111;
    localparam opcode_t OPC_JALR    = 7'b1100111;
    localparam opcode_t OPC_BRANCH  = 7'b1100011;
    localparam opcode_t OPC_ALU_IMM = 7'b0010011;
    localparam opcode_t OPC_ALU_REG = 7'b0110011;

    // alu group funct3, shared by reg-imm and reg-reg forms
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_JALR = 3'b000;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;   // SUB and SRA/SRAI

endpackage

// File: verilog/core_pkg.sv
package core_pkg;

    typedef logic [4:0] alu_op_t;

    localparam alu_op_t ALU_NOP   = 5'd0;
    localparam alu_op_t ALU_ADD   = 5'd1;
    localparam alu_op_t ALU_SUB   = 5'd2;
    localparam alu_op_t ALU_SLL   = 5'd3;
    localparam alu_op_t ALU_SLT   = 5'd4;
    localparam alu_op_t ALU_SLTU  = 5'd5;
    localparam alu_op_t ALU_XOR   = 5'd6;
    localparam alu_op_t ALU_SRL   = 5'd7;
    localparam alu_op_t ALU_SRA   = 5'd8;
    localparam alu_op_t ALU_OR    = 5'd9;
    localparam alu_op_t ALU_AND   = 5'd10;
    localparam alu_op_t ALU_LUI   = 5'd11;
    localparam alu_op_t ALU_AUIPC = 5'd12;
    localparam alu_op_t ALU_JAL   = 5'd13;
    localparam alu_op_t ALU_JALR  = 5'd14;
    localparam alu_op_t ALU_BEQ   = 5'd15;
    localparam alu_op_t ALU_BNE   = 5'd16;
    localparam alu_op_t ALU_BLT   = 5'd17;
    localparam alu_op_t ALU_BGE   = 5'd18;
    localparam alu_op_t ALU_BLTU  = 5'd19;
    localparam alu_op_t ALU_BGEU  = 5'd20;

    typedef struct packed {
        rv_isa_pkg::word_t     pc;
        alu_op_t               alu_op;
        rv_isa_pkg::word_t     rs1_val;
        rv_isa_pkg::word_t     rs2_val;
        rv_isa_pkg::word_t     imm;
        logic                  use_imm;    // operand b from imm instead of rs2
        rv_isa_pkg::reg_addr_t rd;
        logic                  wreg;
        logic                  illegal;
    } decoded_t;

    // valid marks a real instruction slot, bubbles retire nothing
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     wdata;
        logic                  wreg;
        logic                  illegal;
    } ex_result_t;

    typedef struct packed {
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     wdata;
        logic                  wreg;
        logic                  illegal;
    } retire_t;

endpackage

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              redirect_i,
    input  rv_isa_pkg::word_t target_i,
    input  rv_isa_pkg::word_t imem_data_i,
    output rv_isa_pkg::word_t imem_addr_o,
    output logic              inst_valid_o,
    output rv_isa_pkg::word_t inst_pc_o,
    output rv_isa_pkg::word_t inst_o
);
    import rv_isa_pkg::*;

    word_t pc_q;
    word_t inst_pc_q;
    word_t inst_q;
    logic  inst_valid_q;

    assign imem_addr_o  = pc_q;
    assign inst_valid_o = inst_valid_q;
    assign inst_pc_o    = inst_pc_q;
    assign inst_o       = inst_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q         <= RESET_PC;
            inst_valid_q <= 1'b0;
        end else if (redirect_i) begin
            // word fetched this cycle is on the wrong path
            pc_q         <= target_i;
            inst_valid_q <= 1'b0;
        end else begin
            pc_q         <= pc_q + 32'd4;
            inst_valid_q <= 1'b1;
        end
    end

    // payload only, qualified by inst_valid_q
    always_ff @(posedge clk) begin
        inst_pc_q <= pc_q;
        inst_q    <= imem_data_i;
    end

    // jump targets come from execute, must keep the pc word aligned
    pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00);

endmodule

// File: verilog/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  logic                  inst_valid_i,
    input  rv_isa_pkg::word_t     inst_pc_i,
    input  rv_isa_pkg::word_t     inst_i,
    input  rv_isa_pkg::word_t     rs1_data_i,
    input  rv_isa_pkg::word_t     rs2_data_i,
    output rv_isa_pkg::reg_addr_t rs1_addr_o,
    output rv_isa_pkg::reg_addr_t rs2_addr_o,
    output logic                  rs1_read_o,
    output logic                  rs2_read_o,
    output core_pkg::decoded_t    dec_o
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    word_t     shamt_imm;
    logic      illegal;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    // sign extended from bit 31 as the ISA requires
    assign imm_i     = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b     = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u     = {inst_i[31:12], 12'b0};
    assign imm_j     = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign shamt_imm = {27'b0, inst_i[24:20]};

    always_comb begin
        // nop unless an opcode below claims the word
        dec_o         = '0;
        dec_o.pc      = inst_pc_i;
        dec_o.alu_op  = ALU_NOP;
        dec_o.rs1_val = rs1_data_i;
        dec_o.rs2_val = rs2_data_i;
        rs1_read_o    = 1'b0;
        rs2_read_o    = 1'b0;
        illegal       = 1'b0;

        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                dec_o.alu_op = (opcode == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                dec_o.imm    = imm_u;
                dec_o.rd     = rd;
                dec_o.wreg   = 1'b1;
            end
            OPC_JAL: begin
                dec_o.alu_op = ALU_JAL;
                dec_o.imm    = imm_j;
                dec_o.rd     = rd;
                dec_o.wreg   = 1'b1;
            end
            OPC_JALR: begin
                dec_o.alu_op  = ALU_JALR;
                dec_o.imm     = imm_i;
                dec_o.use_imm = 1'b1;
                dec_o.rd      = rd;
                dec_o.wreg    = 1'b1;
                rs1_read_o    = 1'b1;
                illegal       = (funct3 != F3_JALR);
            end
            OPC_BRANCH: begin
                dec_o.imm  = imm_b;
                rs1_read_o = 1'b1;
                rs2_read_o = 1'b1;
                case (funct3)
                    F3_BEQ:  dec_o.alu_op = ALU_BEQ;
                    F3_BNE:  dec_o.alu_op = ALU_BNE;
                    F3_BLT:  dec_o.alu_op = ALU_BLT;
                    F3_BGE:  dec_o.alu_op = ALU_BGE;
                    F3_BLTU: dec_o.alu_op = ALU_BLTU;
                    F3_BGEU: dec_o.alu_op = ALU_BGEU;
                    default: illegal = 1'b1;   // 010 and 011 unused
                endcase
            end
            OPC_ALU_IMM: begin
                dec_o.imm     = imm_i;
                dec_o.use_imm = 1'b1;
                dec_o.rd      = rd;
                dec_o.wreg    = 1'b1;
                rs1_read_o    = 1'b1;
                case (funct3)
                    F3_ADD_SUB: dec_o.alu_op = ALU_ADD;
                    F3_SLT:     dec_o.alu_op = ALU_SLT;
                    F3_SLTU:    dec_o.alu_op = ALU_SLTU;
                    F3_XOR:     dec_o.alu_op = ALU_XOR;
                    F3_OR:      dec_o.alu_op = ALU_OR;
                    F3_AND:     dec_o.alu_op = ALU_AND;
                    F3_SLL: begin
                        dec_o.alu_op = ALU_SLL;
                        dec_o.imm    = shamt_imm;
                        illegal      = (funct7 != F7_BASE);
                    end
                    F3_SRL_SRA: begin
                        dec_o.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        dec_o.imm    = shamt_imm;
                        illegal      = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                    end
                endcase
            end
            OPC_ALU_REG: begin
                dec_o.rd   = rd;
                dec_o.wreg = 1'b1;
                rs1_read_o = 1'b1;
                rs2_read_o = 1'b1;
                case (funct3)
                    F3_ADD_SUB: dec_o.alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec_o.alu_op = ALU_SLL;
                    F3_SLT:     dec_o.alu_op = ALU_SLT;
                    F3_SLTU:    dec_o.alu_op = ALU_SLTU;
                    F3_XOR:     dec_o.alu_op = ALU_XOR;
                    F3_SRL_SRA: dec_o.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec_o.alu_op = ALU_OR;
                    F3_AND:     dec_o.alu_op = ALU_AND;
                endcase
                // alt funct7 only exists for SUB and SRA
                illegal = !((funct7 == F7_BASE) ||
                            ((funct7 == F7_ALT) &&
                             ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA))));
            end
            default: illegal = 1'b1;
        endcase

        // bubble or unknown word collapses back to the nop form
        if (illegal || !inst_valid_i) begin
            dec_o.alu_op  = ALU_NOP;
            dec_o.imm     = '0;
            dec_o.use_imm = 1'b0;
            dec_o.rd      = '0;
            dec_o.wreg    = 1'b0;
            rs1_read_o    = 1'b0;
            rs2_read_o    = 1'b0;
        end
        dec_o.illegal = illegal && inst_valid_i;
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  reset_i,
    input  rv_isa_pkg::reg_addr_t rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t rs2_addr_i,
    input  logic                  rs1_read_i,
    input  logic                  rs2_read_i,
    input  logic                  we_i,
    input  rv_isa_pkg::reg_addr_t waddr_i,
    input  rv_isa_pkg::word_t     wdata_i,
    output rv_isa_pkg::word_t     rs1_data_o,
    output rv_isa_pkg::word_t     rs2_data_o
);
    import rv_isa_pkg::*;

    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write lands at the edge the next instruction enters decode, no bypass
    assign rs1_data_o = (rs1_read_i && (rs1_addr_i != '0)) ? regs[rs1_addr_i] : '0;
    assign rs2_data_o = (rs2_read_i && (rs2_addr_i != '0)) ? regs[rs2_addr_i] : '0;

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  core_pkg::decoded_t   dec_i,
    output logic                 redirect_o,
    output rv_isa_pkg::word_t    target_o,
    output core_pkg::ex_result_t res_o
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      pc_rel;
    word_t      link;
    word_t      jalr_sum;
    word_t      alu_res;
    logic       take_branch;

    assign op_a     = dec_i.rs1_val;
    assign op_b     = dec_i.use_imm ? dec_i.imm : dec_i.rs2_val;
    assign shamt    = op_b[4:0];
    assign pc_rel   = dec_i.pc + dec_i.imm;    // branch, JAL and AUIPC
    assign link     = dec_i.pc + 32'd4;
    assign jalr_sum = op_a + dec_i.imm;

    always_comb begin
        alu_res     = '0;
        take_branch = 1'b0;
        case (dec_i.alu_op)
            ALU_ADD:   alu_res = op_a + op_b;
            ALU_SUB:   alu_res = op_a - op_b;
            ALU_SLL:   alu_res = op_a << shamt;
            ALU_SLT:   alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:  alu_res = {31'b0, op_a < op_b};
            ALU_XOR:   alu_res = op_a ^ op_b;
            ALU_SRL:   alu_res = op_a >> shamt;
            ALU_SRA:   alu_res = word_t'($signed(op_a) >>> shamt);
            ALU_OR:    alu_res = op_a | op_b;
            ALU_AND:   alu_res = op_a & op_b;
            ALU_LUI:   alu_res = dec_i.imm;
            ALU_AUIPC: alu_res = pc_rel;
            ALU_JAL,
            ALU_JALR:  alu_res = link;
            ALU_BEQ:   take_branch = (op_a == op_b);
            ALU_BNE:   take_branch = (op_a != op_b);
            ALU_BLT:   take_branch = ($signed(op_a) < $signed(op_b));
            ALU_BGE:   take_branch = ($signed(op_a) >= $signed(op_b));
            ALU_BLTU:  take_branch = (op_a < op_b);
            ALU_BGEU:  take_branch = (op_a >= op_b);
            default:   alu_res = '0;
        endcase
    end

    always_comb begin
        redirect_o = 1'b0;
        target_o   = pc_rel;
        if (dec_i.alu_op == ALU_JALR) begin
            redirect_o = 1'b1;
            target_o   = {jalr_sum[31:1], 1'b0};
        end else if ((dec_i.alu_op == ALU_JAL) || take_branch) begin
            redirect_o = 1'b1;
        end
    end

    // a bubble is ALU_NOP without illegal
    assign res_o.valid   = (dec_i.alu_op != ALU_NOP) || dec_i.illegal;
    assign res_o.pc      = dec_i.pc;
    assign res_o.rd      = dec_i.rd;
    assign res_o.wdata   = alu_res;
    assign res_o.wreg    = dec_i.wreg;
    assign res_o.illegal = dec_i.illegal;

endmodule

// File: verilog/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit (
    input  logic                  clk,
    input  logic                  reset_i,
    input  core_pkg::ex_result_t  res_i,
    output logic                  rf_we_o,
    output rv_isa_pkg::reg_addr_t rf_waddr_o,
    output rv_isa_pkg::word_t     rf_wdata_o,
    output logic                  retire_valid_o,
    output core_pkg::retire_t     retire_o
);
    logic we;

    assign we = res_i.valid && res_i.wreg && !res_i.illegal && (res_i.rd != '0);

    assign rf_we_o    = we;
    assign rf_waddr_o = res_i.rd;
    assign rf_wdata_o = res_i.wdata;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= res_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_o.pc      <= res_i.pc;
        retire_o.rd      <= res_i.rd;
        retire_o.wdata   <= we ? res_i.wdata : '0;   // zero when nothing written
        retire_o.wreg    <= we;
        retire_o.illegal <= res_i.illegal;
    end

    // decode hands an illegal word over as a nop that targets no register
    illegal_no_write: assert property (@(posedge clk) disable iff (reset_i)
        res_i.illegal |-> !res_i.wreg && (res_i.rd == '0));

endmodule

// File: verilog/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              reset_i,
    input  rv_isa_pkg::word_t imem_data_i,
    output rv_isa_pkg::word_t imem_addr_o,
    output logic              retire_valid_o,
    output core_pkg::retire_t retire_o
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic       inst_valid;
    word_t      inst_pc;
    word_t      inst;
    logic       redirect;
    word_t      target;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    logic       rs1_read;
    logic       rs2_read;
    word_t      rs1_data;
    word_t      rs2_data;
    decoded_t   dec;
    ex_result_t ex_res;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    word_t      rf_wdata;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) i_fetch_unit (
        .clk          (clk),
        .reset_i      (reset_i),
        .redirect_i   (redirect),
        .target_i     (target),
        .imem_data_i  (imem_data_i),
        .imem_addr_o  (imem_addr_o),
        .inst_valid_o (inst_valid),
        .inst_pc_o    (inst_pc),
        .inst_o       (inst)
    );

    decode_unit i_decode_unit (
        .inst_valid_i (inst_valid),
        .inst_pc_i    (inst_pc),
        .inst_i       (inst),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_read_o   (rs1_read),
        .rs2_read_o   (rs2_read),
        .dec_o        (dec)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_read_i (rs1_read),
        .rs2_read_i (rs2_read),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute_unit i_execute_unit (
        .dec_i      (dec),
        .redirect_o (redirect),
        .target_o   (target),
        .res_o      (ex_res)
    );

    writeback_unit i_writeback_unit (
        .clk            (clk),
        .reset_i        (reset_i),
        .res_i          (ex_res),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

// File: sim/iss_model.svh
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

    localparam word_t LFSR_TAPS = 32'hB4BC_D35C;

    word_t lfsr_state;
    word_t ref_regs [0:31];
    word_t ref_pc;

    // one Galois step per bit, the bit shifted out is the random bit
    function automatic word_t take_bits(int n);
        word_t value;
        logic  out_bit;
        value = '0;
        for (int i = 0; i < n; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (out_bit ? LFSR_TAPS : '0);
            value      = {value[30:0], out_bit};
        end
        return value;
    endfunction

    // unsupported opcodes, or bad funct fields on supported ones
    function automatic word_t make_illegal(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        word_t insn;
        insn = take_bits(32);
        case (2'(take_bits(2)))
            2'd0:    insn[6:0] = insn[7] ? 7'b0000011 : 7'b1110011;   // load or system
            2'd1:    insn = {insn[31:25], rs2, rs1, 2'b01, insn[12], insn[11:7], OPC_BRANCH};
            2'd2:    insn = {insn[31:26], 1'b1, rs2, rs1, insn[14:12], rd, OPC_ALU_REG};
            default: insn = {insn[31:20], rs1, insn[14:13], 1'b1, rd, OPC_JALR};
        endcase
        return insn;
    endfunction

    function automatic word_t make_instruction();
        logic [3:0]  kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        funct3_t     f3;
        funct7_t     f7;
        logic [11:0] imm;
        word_t       step;
        word_t       insn;
        kind = 4'(take_bits(4));
        rd   = reg_addr_t'(take_bits(5));
        rs1  = reg_addr_t'(take_bits(5));
        rs2  = reg_addr_t'(take_bits(5));
        f3   = funct3_t'(take_bits(3));
        f7   = F7_BASE;
        imm  = 12'(take_bits(12));
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd14: begin
                if ((f3 == F3_ADD_SUB) || (f3 == F3_SRL_SRA)) begin
                    f7 = (take_bits(1) != '0) ? F7_ALT : F7_BASE;
                end
                insn = {f7, rs2, rs1, f3, rd, OPC_ALU_REG};
            end
            4'd3, 4'd4, 4'd5, 4'd15: begin
                if (f3 == F3_SLL) imm[11:5] = F7_BASE;
                if (f3 == F3_SRL_SRA) imm[11:5] = (take_bits(1) != '0) ? F7_ALT : F7_BASE;
                insn = {imm, rs1, f3, rd, OPC_ALU_IMM};
            end
            4'd6: insn = {20'(take_bits(20)), rd, OPC_LUI};
            4'd7: insn = {20'(take_bits(20)), rd, OPC_AUIPC};
            4'd8: begin
                step = take_bits(6) - 32'd16;   // -16 .. +47 instructions
                if (step == '0) step = 32'd1;
                step = step << 2;
                insn = {step[20], step[10:1], step[11], step[19:12], rd, OPC_JAL};
            end
            4'd9: begin
                // x0 base, so the target is an absolute aligned address
                imm  = {2'b00, 8'(take_bits(8)), 2'b00};
                insn = {imm, 5'd0, F3_JALR, rd, OPC_JALR};
            end
            4'd13: insn = make_illegal(rd, rs1, rs2);
            default: begin
                f3   = (f3[2:1] == 2'b01) ? {2'b00, f3[0]} : f3;   // skip 010 and 011
                step = take_bits(5) - 32'd8;
                if (step == '0) step = 32'd1;
                step = step << 2;
                insn = {step[12], step[10:5], rs2, rs1, f3, step[4:1], step[11], OPC_BRANCH};
            end
        endcase
        return insn;
    endfunction

    task automatic clear_reference(word_t start_pc);
        for (int i = 0; i < 32; i++) begin
            ref_regs[i[4:0]] = '0;
        end
        ref_pc = start_pc;
    endtask

    function automatic word_t alu_result(funct3_t f3, logic alt, word_t a, word_t b);
        word_t r;
        case (f3)
            F3_ADD_SUB: r = alt ? (a - b) : (a + b);
            F3_SLL:     r = a << b[4:0];
            F3_SLT:     r = {31'b0, $signed(a) < $signed(b)};
            F3_SLTU:    r = {31'b0, a < b};
            F3_XOR:     r = a ^ b;
            F3_SRL_SRA: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            F3_OR:      r = a | b;
            default:    r = a & b;
        endcase
        return r;
    endfunction

    // expected retire record of one instruction, model state moves on
    function automatic retire_t execute_reference(word_t insn);
        retire_t rec;
        funct3_t f3;
        logic    alt;
        logic    writes;
        logic    legal;
        logic    taken;
        word_t   a;
        word_t   b;
        word_t   imm_i;
        word_t   res;
        word_t   next_pc;
        f3      = insn[14:12];
        alt     = (insn[31:25] == F7_ALT);
        a       = ref_regs[insn[19:15]];
        b       = ref_regs[insn[24:20]];
        imm_i   = {{20{insn[31]}}, insn[31:20]};
        res     = '0;
        writes  = 1'b0;
        legal   = 1'b1;
        taken   = 1'b0;
        next_pc = ref_pc + 32'd4;
        case (insn[6:0])
            OPC_LUI, OPC_AUIPC: begin
                res    = {insn[31:12], 12'b0};
                res    = (insn[6:0] == OPC_AUIPC) ? (ref_pc + res) : res;
                writes = 1'b1;
            end
            OPC_JAL: begin
                res     = ref_pc + 32'd4;
                next_pc = ref_pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
                writes  = 1'b1;
            end
            OPC_JALR: begin
                legal   = (f3 == F3_JALR);
                res     = ref_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
                writes  = 1'b1;
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_BEQ:  taken = (a == b);
                    F3_BNE:  taken = (a != b);
                    F3_BLT:  taken = ($signed(a) < $signed(b));
                    F3_BGE:  taken = ($signed(a) >= $signed(b));
                    F3_BLTU: taken = (a < b);
                    F3_BGEU: taken = (a >= b);
                    default: legal = 1'b0;
                endcase
                if (taken) begin
                    next_pc = ref_pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
                end
            end
            OPC_ALU_IMM: begin
                if (f3 == F3_SLL) legal = (insn[31:25] == F7_BASE);
                if (f3 == F3_SRL_SRA) legal = (insn[31:25] == F7_BASE) || alt;
                res    = alu_result(f3, alt && (f3 == F3_SRL_SRA), a, imm_i);
                writes = 1'b1;
            end
            OPC_ALU_REG: begin
                legal  = (insn[31:25] == F7_BASE) ||
                         (alt && ((f3 == F3_ADD_SUB) || (f3 == F3_SRL_SRA)));
                res    = alu_result(f3, alt, a, b);
                writes = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            writes  = 1'b0;
            next_pc = ref_pc + 32'd4;
        end
        rec.pc      = ref_pc;
        rec.rd      = writes ? insn[11:7] : 5'd0;
        rec.wreg    = writes && (insn[11:7] != 5'd0);
        rec.wdata   = rec.wreg ? res : '0;
        rec.illegal = !legal;
        if (rec.wreg) ref_regs[insn[11:7]] = res;
        ref_pc = next_pc;
        return rec;
    endfunction

`endif

// File: sim/tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam word_t RESET_PC    = 32'h0000_0100;
    localparam word_t LFSR_SEED   = 32'd89268;
    localparam int    NUM_RETIRES = 2000;
    localparam int    WAIT_LIMIT  = 8;   // one bubble per redirect, so plenty

    logic    clk;
    logic    reset_i;
    word_t   imem_data_i;
    word_t   imem_addr_o;
    logic    retire_valid_o;
    retire_t retire_o;

    word_t imem [0:255];

    `include "iss_model.svh"

    core_top #(
        .RESET_PC (RESET_PC)
    ) i_core_top (
        .clk            (clk),
        .reset_i        (reset_i),
        .imem_data_i    (imem_data_i),
        .imem_addr_o    (imem_addr_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    // answers in the same cycle, address wraps every 1 KiB
    assign imem_data_i = imem[imem_addr_o[9:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(string name, word_t got, word_t expected);
        $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, expected);
        stop_with_failure();
    endtask

    task automatic check_word(string name, word_t got, word_t expected);
        if (got !== expected) report_mismatch(name, got, expected);
    endtask

    task automatic check_bit(string name, logic got, logic expected);
        if (got !== expected) report_mismatch(name, word_t'(got), word_t'(expected));
    endtask

    task automatic check_retire(retire_t got, retire_t expected);
        check_word("retire_o.pc", got.pc, expected.pc);
        check_word("retire_o.rd", word_t'(got.rd), word_t'(expected.rd));
        check_word("retire_o.wdata", got.wdata, expected.wdata);
        check_bit("retire_o.wreg", got.wreg, expected.wreg);
        check_bit("retire_o.illegal", got.illegal, expected.illegal);
    endtask

    // samples at the falling edge, returns in a cycle with the strobe high
    task automatic wait_retire();
        int cycles;
        cycles = 0;
        while (retire_valid_o !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                $display("no retire strobe for %0d cycles, the core hangs", WAIT_LIMIT);
                stop_with_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        retire_t expected;
        reset_i    = 1'b1;
        lfsr_state = LFSR_SEED;
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = make_instruction();
        end
        clear_reference(RESET_PC);

        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        // first cycle out of reset, fetch register still empty
        @(negedge clk);
        check_bit("retire_valid_o", retire_valid_o, 1'b0);
        check_word("imem_addr_o", imem_addr_o, RESET_PC);

        for (int n = 0; n < NUM_RETIRES; n++) begin
            @(negedge clk);
            wait_retire();
            expected = execute_reference(imem[ref_pc[9:2]]);
            if (n == 0) check_word("retire_o.pc", retire_o.pc, RESET_PC);
            check_retire(retire_o, expected);
        end

        $display("%0d retires matched the reference model", NUM_RETIRES);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: files.f
+incdir+sim
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/writeback_unit.sv
verilog/core_top.sv
sim/tb_core_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the core testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
log_file=sim.log

verilator --binary --timing --assert --top-module tb_core_top -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_core_top > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -qx "Simulation PASSED" "$log_file"; then
    exit 0
fi
exit 1
